//--- isaPkg.sv
package isaPkg;

    // R-type field layout
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields;

    // I-type field layout
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFields;

    // One instruction word, read through either view
    typedef union packed {
        rFields r;
        iFields i;
    } instrWord;

    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    localparam logic [5:0] OP_BNE   = 6'b000101;
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_ADDIU = 6'b001001;
    localparam logic [5:0] OP_SLTI  = 6'b001010;
    localparam logic [5:0] OP_SLTIU = 6'b001011;
    localparam logic [5:0] OP_ANDI  = 6'b001100;
    localparam logic [5:0] OP_ORI   = 6'b001101;
    localparam logic [5:0] OP_XORI  = 6'b001110;

    localparam logic [5:0] FUNCT_ADD   = 6'b100000;
    localparam logic [5:0] FUNCT_ADDU  = 6'b100001;
    localparam logic [5:0] FUNCT_SUB   = 6'b100010;
    localparam logic [5:0] FUNCT_MULT  = 6'b011000;
    localparam logic [5:0] FUNCT_MULTU = 6'b011001;
    localparam logic [5:0] FUNCT_AND   = 6'b100100;
    localparam logic [5:0] FUNCT_OR    = 6'b100101;
    localparam logic [5:0] FUNCT_NOR   = 6'b100111;
    localparam logic [5:0] FUNCT_XOR   = 6'b100110;
    localparam logic [5:0] FUNCT_SLL   = 6'b000000;
    localparam logic [5:0] FUNCT_SRL   = 6'b000010;
    localparam logic [5:0] FUNCT_SLLV  = 6'b000100;
    localparam logic [5:0] FUNCT_SLT   = 6'b101010;
    localparam logic [5:0] FUNCT_MOVN  = 6'b001011;
    localparam logic [5:0] FUNCT_MOVZ  = 6'b001010;
    localparam logic [5:0] FUNCT_SRLV  = 6'b000110;
    localparam logic [5:0] FUNCT_SRA   = 6'b000011;
    localparam logic [5:0] FUNCT_SRAV  = 6'b000111;
    localparam logic [5:0] FUNCT_SLTU  = 6'b101011;
    localparam logic [5:0] FUNCT_MFHI  = 6'b010000;
    localparam logic [5:0] FUNCT_MFLO  = 6'b010010;
    localparam logic [5:0] FUNCT_MTHI  = 6'b010001;
    localparam logic [5:0] FUNCT_MTLO  = 6'b010011;
    localparam logic [5:0] FUNCT_JR    = 6'b001000;
    // Multiply group reuses shift encodings under ALUOP_MUL
    localparam logic [5:0] FUNCT_MUL   = 6'b000010;
    localparam logic [5:0] FUNCT_MADD  = 6'b000000;
    localparam logic [5:0] FUNCT_MSUB  = 6'b000100;

endpackage

//--- aluPkg.sv
package aluPkg;

    localparam int DATA_W = 32;

    // Operation codes from the main controller
    localparam logic [4:0] ALUOP_DC        = 5'd0;  // Decode by funct
    localparam logic [4:0] ALUOP_ADDI      = 5'd1;
    localparam logic [4:0] ALUOP_SUBI      = 5'd2;
    localparam logic [4:0] ALUOP_ORI       = 5'd3;
    localparam logic [4:0] ALUOP_ANDI      = 5'd4;
    localparam logic [4:0] ALUOP_XORI      = 5'd5;
    localparam logic [4:0] ALUOP_NORI      = 5'd6;
    localparam logic [4:0] ALUOP_ADDUI     = 5'd7;
    localparam logic [4:0] ALUOP_SUBUI     = 5'd8;
    localparam logic [4:0] ALUOP_MULTUI    = 5'd9;
    localparam logic [4:0] ALUOP_SLTI      = 5'd10;
    localparam logic [4:0] ALUOP_SLTIU     = 5'd11;
    localparam logic [4:0] ALUOP_MUL       = 5'd12; // Multiply group
    localparam logic [4:0] ALUOP_SE        = 5'd13;
    localparam logic [4:0] ALUOP_BEQ       = 5'd14;
    localparam logic [4:0] ALUOP_BNE       = 5'd15;
    localparam logic [4:0] ALUOP_BLTZ_BGEZ = 5'd16;
    localparam logic [4:0] ALUOP_BGTZ      = 5'd17;
    localparam logic [4:0] ALUOP_BLEZ      = 5'd18;

    // Control codes seen by the ALU datapath
    localparam logic [5:0] ALUC_ADD       = 6'd0;
    localparam logic [5:0] ALUC_ADDU      = 6'd1;
    localparam logic [5:0] ALUC_SUB       = 6'd2;
    localparam logic [5:0] ALUC_MULT      = 6'd3;
    localparam logic [5:0] ALUC_MULTU     = 6'd4;
    localparam logic [5:0] ALUC_AND       = 6'd5;
    localparam logic [5:0] ALUC_OR        = 6'd6;
    localparam logic [5:0] ALUC_NOR       = 6'd7;
    localparam logic [5:0] ALUC_XOR       = 6'd8;
    localparam logic [5:0] ALUC_SLL       = 6'd9;
    localparam logic [5:0] ALUC_SRL       = 6'd10;
    localparam logic [5:0] ALUC_SLLV      = 6'd11;
    localparam logic [5:0] ALUC_SLT       = 6'd12;
    localparam logic [5:0] ALUC_MOVN      = 6'd13;
    localparam logic [5:0] ALUC_MOVZ      = 6'd14;
    localparam logic [5:0] ALUC_SRLV      = 6'd15;
    localparam logic [5:0] ALUC_SRA       = 6'd16;
    localparam logic [5:0] ALUC_SRAV      = 6'd17;
    localparam logic [5:0] ALUC_SLTU      = 6'd18;
    localparam logic [5:0] ALUC_MUL       = 6'd19;
    localparam logic [5:0] ALUC_MADD      = 6'd20;
    localparam logic [5:0] ALUC_MSUB      = 6'd21;
    localparam logic [5:0] ALUC_SE        = 6'd22;
    localparam logic [5:0] ALUC_MFHI      = 6'd23;
    localparam logic [5:0] ALUC_MFLO      = 6'd24;
    localparam logic [5:0] ALUC_MTHI      = 6'd25;
    localparam logic [5:0] ALUC_MTLO      = 6'd26;
    localparam logic [5:0] ALUC_EQ        = 6'd27; // Issued for bne
    localparam logic [5:0] ALUC_BLTZ_BGEZ = 6'd28;
    localparam logic [5:0] ALUC_BGTZ      = 6'd29;
    localparam logic [5:0] ALUC_BLEZ      = 6'd30;
    localparam logic [5:0] ALUC_JR        = 6'd31;

endpackage

//--- instrDecode.sv
`timescale 1ns/1ps

module instrDecode import isaPkg::*, aluPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  instrWord          instr,
    input  logic [DATA_W-1:0] rsVal,
    input  logic [DATA_W-1:0] rtVal,
    input  logic              inValid,
    output logic              inReady,
    output logic              decValid,
    input  logic              decReady,
    output logic [4:0]        decAluOp,
    output logic [5:0]        decFunct,
    output logic [DATA_W-1:0] decOpA,
    output logic [DATA_W-1:0] decOpB
);

    logic              inFire;
    logic              supported;
    logic [4:0]        aluOpNext;
    logic [DATA_W-1:0] opANext;
    logic [DATA_W-1:0] opBNext;

    assign inReady = !decValid || decReady; // Empty or draining this cycle
    assign inFire  = inValid && inReady;

    always_comb begin
        supported = 1'b1;
        aluOpNext = ALUOP_DC;
        opANext   = rsVal;
        opBNext   = rtVal;                      // R-type and branches
        case (instr.r.opcode)
            OP_RTYPE: begin
                if (instr.r.funct inside {FUNCT_SLL, FUNCT_SRL, FUNCT_SRA}) begin
                    opANext = rtVal;
                    opBNext = DATA_W'(instr.r.shamt);
                end
            end
            OP_ADDI:  aluOpNext = ALUOP_ADDI;
            OP_ADDIU: aluOpNext = ALUOP_ADDUI;
            OP_ANDI:  aluOpNext = ALUOP_ANDI;
            OP_ORI:   aluOpNext = ALUOP_ORI;
            OP_XORI:  aluOpNext = ALUOP_XORI;
            OP_SLTI:  aluOpNext = ALUOP_SLTI;
            OP_SLTIU: aluOpNext = ALUOP_SLTIU;
            OP_BEQ:   aluOpNext = ALUOP_BEQ;
            OP_BNE:   aluOpNext = ALUOP_BNE;
            default:  supported = 1'b0;         // Swallowed, never forwarded
        endcase
        if (instr.i.opcode inside {OP_ANDI, OP_ORI, OP_XORI}) begin
            opBNext = DATA_W'(instr.i.imm);     // Logical ops zero-extend
        end else if (instr.i.opcode inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU}) begin
            opBNext = DATA_W'($signed(instr.i.imm));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
        end else if (inFire) begin
            decValid <= supported;
        end else if (decReady) begin
            decValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (inFire) begin
            decAluOp <= aluOpNext;
            decFunct <= instr.r.funct;
            decOpA   <= opANext;
            decOpB   <= opBNext;
        end
    end

endmodule

//--- opFifo.sv
`timescale 1ns/1ps

module opFifo import aluPkg::*; #(
    parameter int FifoDepth = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              decValid,
    output logic              decReady,
    input  logic [4:0]        decAluOp,
    input  logic [5:0]        decFunct,
    input  logic [DATA_W-1:0] decOpA,
    input  logic [DATA_W-1:0] decOpB,
    output logic              fifoValid,
    input  logic              fifoReady,
    output logic [4:0]        fifoAluOp,
    output logic [5:0]        fifoFunct,
    output logic [DATA_W-1:0] fifoOpA,
    output logic [DATA_W-1:0] fifoOpB
);

    localparam int PtrW = $clog2(FifoDepth);

    logic [4:0]        aluOpMem [FifoDepth];
    logic [5:0]        functMem [FifoDepth];
    logic [DATA_W-1:0] opAMem   [FifoDepth];
    logic [DATA_W-1:0] opBMem   [FifoDepth];
    logic [PtrW-1:0]   wrPtr;
    logic [PtrW-1:0]   rdPtr;
    logic [PtrW:0]     count;
    logic              push;
    logic              pop;

    assign decReady  = (count != FifoDepth[PtrW:0]);
    assign fifoValid = (count != '0);     // Count is registered, so one cycle after write
    assign push      = decValid && decReady;
    assign pop       = fifoValid && fifoReady;

    assign fifoAluOp = aluOpMem[rdPtr];
    assign fifoFunct = functMem[rdPtr];
    assign fifoOpA   = opAMem[rdPtr];
    assign fifoOpB   = opBMem[rdPtr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) wrPtr <= wrPtr + 1'b1;  // Wraps at power-of-two depth
            if (pop) rdPtr <= rdPtr + 1'b1;
            count <= count + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            aluOpMem[wrPtr] <= decAluOp;
            functMem[wrPtr] <= decFunct;
            opAMem[wrPtr]   <= decOpA;
            opBMem[wrPtr]   <= decOpB;
        end
    end

endmodule

//--- aluControl.sv
`timescale 1ns/1ps

module aluControl import isaPkg::*, aluPkg::*; (
    input  logic [4:0] aluOp,
    input  logic [5:0] funct,
    output logic [5:0] aluCtrl
);

    always_comb begin
        aluCtrl = ALUC_ADD;                    // Fallback for unknown codes
        if (aluOp == ALUOP_DC) begin
            case (funct)
                FUNCT_ADD:   aluCtrl = ALUC_ADD;
                FUNCT_ADDU:  aluCtrl = ALUC_ADDU;
                FUNCT_SUB:   aluCtrl = ALUC_SUB;
                FUNCT_MULT:  aluCtrl = ALUC_MULT;
                FUNCT_MULTU: aluCtrl = ALUC_MULTU;
                FUNCT_AND:   aluCtrl = ALUC_AND;
                FUNCT_OR:    aluCtrl = ALUC_OR;
                FUNCT_NOR:   aluCtrl = ALUC_NOR;
                FUNCT_XOR:   aluCtrl = ALUC_XOR;
                FUNCT_SLL:   aluCtrl = ALUC_SLL;
                FUNCT_SRL:   aluCtrl = ALUC_SRL;
                FUNCT_SLLV:  aluCtrl = ALUC_SLLV;
                FUNCT_SLT:   aluCtrl = ALUC_SLT;
                FUNCT_MOVN:  aluCtrl = ALUC_MOVN;
                FUNCT_MOVZ:  aluCtrl = ALUC_MOVZ;
                FUNCT_SRLV:  aluCtrl = ALUC_SRLV;
                FUNCT_SRA:   aluCtrl = ALUC_SRA;
                FUNCT_SRAV:  aluCtrl = ALUC_SRAV;
                FUNCT_SLTU:  aluCtrl = ALUC_SLTU;
                FUNCT_MFHI:  aluCtrl = ALUC_MFHI;
                FUNCT_MFLO:  aluCtrl = ALUC_MFLO;
                FUNCT_MTHI:  aluCtrl = ALUC_MTHI;
                FUNCT_MTLO:  aluCtrl = ALUC_MTLO;
                FUNCT_JR:    aluCtrl = ALUC_JR;
                default:     aluCtrl = ALUC_ADD;
            endcase
        end else begin
            case (aluOp)
                ALUOP_ADDI:   aluCtrl = ALUC_ADD;
                ALUOP_SUBI:   aluCtrl = ALUC_SUB;
                ALUOP_ORI:    aluCtrl = ALUC_OR;
                ALUOP_ANDI:   aluCtrl = ALUC_AND;
                ALUOP_XORI:   aluCtrl = ALUC_XOR;
                ALUOP_NORI:   aluCtrl = ALUC_NOR;
                ALUOP_ADDUI:  aluCtrl = ALUC_ADDU;
                ALUOP_SUBUI:  aluCtrl = ALUC_SUB;
                ALUOP_MULTUI: aluCtrl = ALUC_MULT;
                ALUOP_SLTI:   aluCtrl = ALUC_SLT;
                ALUOP_SLTIU:  aluCtrl = ALUC_SLTU;
                ALUOP_MUL: begin
                    // Multiply group picks its variant from funct
                    if (funct == FUNCT_MUL) begin
                        aluCtrl = ALUC_MUL;
                    end else if (funct == FUNCT_MADD) begin
                        aluCtrl = ALUC_MADD;
                    end else if (funct == FUNCT_MSUB) begin
                        aluCtrl = ALUC_MSUB;
                    end
                end
                ALUOP_SE:        aluCtrl = ALUC_SE;
                ALUOP_BEQ:       aluCtrl = ALUC_SUB;  // Zero difference means taken
                ALUOP_BNE:       aluCtrl = ALUC_EQ;
                ALUOP_BLTZ_BGEZ: aluCtrl = ALUC_BLTZ_BGEZ;
                ALUOP_BGTZ:      aluCtrl = ALUC_BGTZ;
                ALUOP_BLEZ:      aluCtrl = ALUC_BLEZ;
                default:         aluCtrl = ALUC_ADD;
            endcase
        end
    end

endmodule

//--- aluExec.sv
`timescale 1ns/1ps

module aluExec import aluPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              fifoValid,
    output logic              fifoReady,
    input  logic [4:0]        fifoAluOp,
    input  logic [5:0]        fifoFunct,
    input  logic [DATA_W-1:0] fifoOpA,
    input  logic [DATA_W-1:0] fifoOpB,
    output logic [DATA_W-1:0] result,
    output logic              outValid,
    input  logic              outReady
);

    logic [5:0]        aluCtrl;
    logic [4:0]        shAmt;
    logic [DATA_W-1:0] aluResult;

    aluControl ctrlDec (
        .aluOp   (fifoAluOp),
        .funct   (fifoFunct),
        .aluCtrl (aluCtrl)
    );

    assign shAmt     = fifoOpB[4:0];
    assign fifoReady = !outValid || outReady; // Stall while result is held

    always_comb begin
        case (aluCtrl)
            ALUC_ADD, ALUC_ADDU: aluResult = fifoOpA + fifoOpB;
            ALUC_SUB: begin
                if (fifoAluOp == ALUOP_BEQ) begin
                    aluResult = DATA_W'(fifoOpA == fifoOpB); // Taken flag
                end else begin
                    aluResult = fifoOpA - fifoOpB;
                end
            end
            ALUC_EQ:   aluResult = DATA_W'(fifoOpA != fifoOpB);   // bne taken flag
            ALUC_AND:  aluResult = fifoOpA & fifoOpB;
            ALUC_OR:   aluResult = fifoOpA | fifoOpB;
            ALUC_NOR:  aluResult = ~(fifoOpA | fifoOpB);
            ALUC_XOR:  aluResult = fifoOpA ^ fifoOpB;
            ALUC_SLL:  aluResult = fifoOpA << shAmt;
            ALUC_SRL:  aluResult = fifoOpA >> shAmt;
            ALUC_SRA:  aluResult = $signed(fifoOpA) >>> shAmt;
            ALUC_SLT:  aluResult = DATA_W'($signed(fifoOpA) < $signed(fifoOpB));
            ALUC_SLTU: aluResult = DATA_W'(fifoOpA < fifoOpB);
            default:   aluResult = '0;                     // Not implemented here
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (fifoValid && fifoReady) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fifoValid && fifoReady) begin
            result <= aluResult;
        end
    end

endmodule

//--- aluSliceTop.sv
`timescale 1ns/1ps

module aluSliceTop import isaPkg::*, aluPkg::*; #(
    parameter int FifoDepth = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  instrWord          instr,
    input  logic [DATA_W-1:0] rsVal,
    input  logic [DATA_W-1:0] rtVal,
    input  logic              inValid,
    output logic              inReady,
    output logic [DATA_W-1:0] result,
    output logic              outValid,
    input  logic              outReady
);

    // Decode stage to FIFO
    logic              decValid;
    logic              decReady;
    logic [4:0]        decAluOp;
    logic [5:0]        decFunct;
    logic [DATA_W-1:0] decOpA;
    logic [DATA_W-1:0] decOpB;

    // FIFO to execute stage
    logic              fifoValid;
    logic              fifoReady;
    logic [4:0]        fifoAluOp;
    logic [5:0]        fifoFunct;
    logic [DATA_W-1:0] fifoOpA;
    logic [DATA_W-1:0] fifoOpB;

    instrDecode decStage (
        .clk      (clk),
        .rst      (rst),
        .instr    (instr),
        .rsVal    (rsVal),
        .rtVal    (rtVal),
        .inValid  (inValid),
        .inReady  (inReady),
        .decValid (decValid),
        .decReady (decReady),
        .decAluOp (decAluOp),
        .decFunct (decFunct),
        .decOpA   (decOpA),
        .decOpB   (decOpB)
    );

    opFifo #(
        .FifoDepth (FifoDepth)
    ) opBuf (
        .clk       (clk),
        .rst       (rst),
        .decValid  (decValid),
        .decReady  (decReady),
        .decAluOp  (decAluOp),
        .decFunct  (decFunct),
        .decOpA    (decOpA),
        .decOpB    (decOpB),
        .fifoValid (fifoValid),
        .fifoReady (fifoReady),
        .fifoAluOp (fifoAluOp),
        .fifoFunct (fifoFunct),
        .fifoOpA   (fifoOpA),
        .fifoOpB   (fifoOpB)
    );

    aluExec execStage (
        .clk       (clk),
        .rst       (rst),
        .fifoValid (fifoValid),
        .fifoReady (fifoReady),
        .fifoAluOp (fifoAluOp),
        .fifoFunct (fifoFunct),
        .fifoOpA   (fifoOpA),
        .fifoOpB   (fifoOpB),
        .result    (result),
        .outValid  (outValid),
        .outReady  (outReady)
    );

endmodule

//--- aluSlice_chk.sv
`timescale 1ns/1ps

module aluSlice_chk import aluPkg::*; (
    input logic              clk,
    input logic              rst,
    input logic [DATA_W-1:0] instr,
    input logic [DATA_W-1:0] rsVal,
    input logic [DATA_W-1:0] rtVal,
    input logic              inValid,
    input logic              inReady,
    input logic              decValid,
    input logic              decReady,
    input logic [4:0]        decAluOp,
    input logic [5:0]        decFunct,
    input logic [DATA_W-1:0] decOpA,
    input logic [DATA_W-1:0] decOpB,
    input logic              fifoValid,
    input logic              fifoReady,
    input logic [4:0]        fifoAluOp,
    input logic [5:0]        fifoFunct,
    input logic [DATA_W-1:0] fifoOpA,
    input logic [DATA_W-1:0] fifoOpB,
    input logic [DATA_W-1:0] result,
    input logic              outValid,
    input logic              outReady
);

    int failCount = 0;  // Read by the testbench

    resetClears: assert property (@(posedge clk) rst |=> !decValid && !fifoValid && !outValid)
        else begin
            $error("Valid flags not cleared by reset");
            failCount++;
        end

    inHold: assert property (@(posedge clk) disable iff (rst)
        inValid && !inReady |=> inValid && $stable({instr, rsVal, rtVal}))
        else begin
            $error("Input channel dropped or changed before transfer");
            failCount++;
        end

    decHold: assert property (@(posedge clk) disable iff (rst)
        decValid && !decReady |=> decValid && $stable({decAluOp, decFunct, decOpA, decOpB}))
        else begin
            $error("Decode channel dropped or changed before transfer");
            failCount++;
        end

    fifoHold: assert property (@(posedge clk) disable iff (rst)
        fifoValid && !fifoReady |=> fifoValid && $stable({fifoAluOp, fifoFunct, fifoOpA, fifoOpB}))
        else begin
            $error("FIFO output dropped or changed before transfer");
            failCount++;
        end

    outHold: assert property (@(posedge clk) disable iff (rst)
        outValid && !outReady |=> outValid && $stable(result))
        else begin
            $error("Result dropped or changed under back-pressure");
            failCount++;
        end

endmodule

bind aluSliceTop aluSlice_chk chk (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .rsVal     (rsVal),
    .rtVal     (rtVal),
    .inValid   (inValid),
    .inReady   (inReady),
    .decValid  (decValid),
    .decReady  (decReady),
    .decAluOp  (decAluOp),
    .decFunct  (decFunct),
    .decOpA    (decOpA),
    .decOpB    (decOpB),
    .fifoValid (fifoValid),
    .fifoReady (fifoReady),
    .fifoAluOp (fifoAluOp),
    .fifoFunct (fifoFunct),
    .fifoOpA   (fifoOpA),
    .fifoOpB   (fifoOpB),
    .result    (result),
    .outValid  (outValid),
    .outReady  (outReady)
);

//--- tbTop.sv
`timescale 1ns/1ps

module tbTop import isaPkg::*, aluPkg::*; ();

    localparam int NumR       = 40;
    localparam int NumI       = 40;
    localparam int NumBr      = 24;
    localparam int NumBp      = 60;
    localparam int NumBad     = 40;
    localparam int TotalInstr = NumR + NumI + NumBr + NumBp + NumBad;
    localparam int CycleLimit = 10 * TotalInstr + 200;

    localparam int KindR   = 0;
    localparam int KindI   = 1;
    localparam int KindBr  = 2;
    localparam int KindBad = 3;
    localparam int KindAny = 4;  // Any supported kind
    localparam int KindMix = 5;  // Supported or not

    localparam logic [5:0] RFuncts [12] = '{FUNCT_ADD, FUNCT_ADDU, FUNCT_SUB, FUNCT_AND,
        FUNCT_OR, FUNCT_NOR, FUNCT_XOR, FUNCT_SLL, FUNCT_SRL, FUNCT_SRA, FUNCT_SLT, FUNCT_SLTU};
    localparam logic [5:0] IOps [7] = '{OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI,
        OP_SLTI, OP_SLTIU};

    logic              clk = 1'b0;
    logic              rst;
    instrWord          instr;
    logic [DATA_W-1:0] rsVal;
    logic [DATA_W-1:0] rtVal;
    logic              inValid;
    logic              inReady;
    logic [DATA_W-1:0] result;
    logic              outValid;
    logic              outReady = 1'b1;

    logic [DATA_W-1:0] expQ [$];  // Expected results in issue order
    logic              stallMode = 1'b0;
    int                errCount  = 0;
    int                checked   = 0;
    int                cycles    = 0;
    int                testNum   = 0;
    int                lastChecked = 0;
    int                lastErr     = 0;

    aluSliceTop #(.FifoDepth(4)) dut (
        .clk      (clk),
        .rst      (rst),
        .instr    (instr),
        .rsVal    (rsVal),
        .rtVal    (rtVal),
        .inValid  (inValid),
        .inReady  (inReady),
        .result   (result),
        .outValid (outValid),
        .outReady (outReady)
    );

    always #50 clk = ~clk;

    // Tb checks plus bound checker failures
    function automatic int errNow();
        return errCount + dut.chk.failCount;
    endfunction

    // Returns {supported, expected result} from the ISA rules
    function automatic logic [32:0] refModel(instrWord w, logic [31:0] rs, logic [31:0] rt);
        logic [31:0] sImm;
        logic [31:0] zImm;
        logic [31:0] r;
        logic        ok;
        sImm = {{16{w.i.imm[15]}}, w.i.imm};
        zImm = {16'h0000, w.i.imm};
        ok   = 1'b1;
        r    = '0;
        case (w.r.opcode)
            OP_RTYPE: begin
                case (w.r.funct)
                    FUNCT_ADD, FUNCT_ADDU: r = rs + rt;  // Wraps mod 2^32
                    FUNCT_SUB:  r = rs - rt;
                    FUNCT_AND:  r = rs & rt;
                    FUNCT_OR:   r = rs | rt;
                    FUNCT_NOR:  r = ~(rs | rt);
                    FUNCT_XOR:  r = rs ^ rt;
                    FUNCT_SLL:  r = rt << w.r.shamt;
                    FUNCT_SRL:  r = rt >> w.r.shamt;
                    FUNCT_SRA:  r = $signed(rt) >>> w.r.shamt;
                    FUNCT_SLT:  r = {31'b0, $signed(rs) < $signed(rt)};
                    FUNCT_SLTU: r = {31'b0, rs < rt};
                    default:    r = '0;  // Never issued
                endcase
            end
            OP_ADDI, OP_ADDIU: r = rs + sImm;
            OP_SLTI:  r = {31'b0, $signed(rs) < $signed(sImm)};
            OP_SLTIU: r = {31'b0, rs < sImm};
            OP_ANDI:  r = rs & zImm;
            OP_ORI:   r = rs | zImm;
            OP_XORI:  r = rs ^ zImm;
            OP_BEQ:   r = {31'b0, rs == rt};  // Taken flag
            OP_BNE:   r = {31'b0, rs != rt};
            default:  ok = 1'b0;  // Dropped by the decoder
        endcase
        return {ok, r};
    endfunction

    // Corner values now and then to hit wrap and sign cases
    function automatic logic [31:0] randOperand();
        case ($urandom_range(0, 7))
            0: return 32'hffff_ffff;
            1: return 32'h8000_0000;
            2: return 32'h7fff_ffff;
            3: return 32'h0000_0000;
            default: return $urandom;
        endcase
    endfunction

    task automatic makeInstr(input int kind, output instrWord w, output logic [31:0] rs,
                             output logic [31:0] rt);
        int         k;
        logic [5:0] op;
        k  = kind;
        w  = $urandom;  // Random fields, opcode fixed below
        rs = randOperand();
        rt = randOperand();
        if (k == KindAny) k = $urandom_range(0, 2);
        if (k == KindMix) k = $urandom_range(KindR, KindBad);
        case (k)
            KindR: begin
                w.r.opcode = OP_RTYPE;
                w.r.funct  = RFuncts[$urandom_range(0, 11)];
            end
            KindI:  w.i.opcode = IOps[$urandom_range(0, 6)];
            KindBr: begin
                w.i.opcode = $urandom_range(0, 1) ? OP_BEQ : OP_BNE;
                if ($urandom_range(0, 1) == 0) rt = rs;  // Half taken for beq
            end
            default: begin
                do begin
                    op = 6'($urandom);
                end while (op inside {OP_RTYPE, OP_BEQ, OP_BNE, OP_ADDI, OP_ADDIU,
                                      OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI});
                w.i.opcode = op;
            end
        endcase
    endtask

    task automatic sendInstr(input instrWord w, input logic [31:0] rs, input logic [31:0] rt);
        instr   <= w;
        rsVal   <= rs;
        rtVal   <= rt;
        inValid <= 1'b1;
        @(posedge clk);
        while (!inReady) @(posedge clk);  // Held until accepted
        inValid <= 1'b0;
    endtask

    task automatic drain();
        repeat (3) @(posedge clk);
        while (expQ.size() != 0) @(posedge clk);
    endtask

    task automatic runBatch(input int kind, input int count);
        instrWord    w;
        logic [31:0] a;
        logic [31:0] b;
        for (int n = 0; n < count; n++) begin
            makeInstr(kind, w, a, b);
            sendInstr(w, a, b);
        end
        drain();
    endtask

    task automatic report(input string name);
        testNum++;
        $display("Test %0d (%s) finished: %0d results checked, %0d errors",
                 testNum, name, checked - lastChecked, errNow() - lastErr);
        lastChecked = checked;
        lastErr     = errNow();
    endtask

    // Scoreboard
    always @(posedge clk) begin
        logic [32:0] predicted;
        if (!rst) begin
            predicted = refModel(instr, rsVal, rtVal);
            if (inValid && inReady && predicted[32]) expQ.push_back(predicted[31:0]);
            if (outValid && outReady) begin
                assert (expQ.size() != 0) else begin
                    $display("Result came out at %0t with no instruction pending", $time);
                    errCount++;
                end
                if (expQ.size() != 0) begin
                    assert (result == expQ[0]) else begin
                        $display("FAIL %0t: result %h, expected %h", $time, result, expQ[0]);
                        errCount++;
                    end
                    void'(expQ.pop_front());
                    checked++;
                end
            end
        end
    end

    // Back-pressure in random stretches
    always @(posedge clk) begin
        if (stallMode) outReady <= ($urandom_range(0, 2) == 0);
        else outReady <= 1'b1;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("Timeout after %0d cycles, %0d results never came out", cycles, expQ.size());
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hf773));
        rst     = 1'b1;
        inValid = 1'b0;
        instr   = '0;
        rsVal   = '0;
        rtVal   = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (20) begin
            @(posedge clk);
            assert (!outValid) else begin
                $display("Output valid at %0t before any instruction was sent", $time);
                errCount++;
            end
        end
        report("reset and idle");
        runBatch(KindR, NumR);
        report("R-type");
        runBatch(KindI, NumI);
        report("I-type");
        runBatch(KindBr, NumBr);
        report("branches");
        stallMode <= 1'b1;
        runBatch(KindAny, NumBp);
        stallMode <= 1'b0;
        report("back-pressure");
        runBatch(KindMix, NumBad);
        report("unsupported opcodes");
        $display("Closing: %0d results checked, %0d errors", checked, errNow());
        if (errNow() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- src.f
isaPkg.sv
aluPkg.sv
instrDecode.sv
opFifo.sv
aluControl.sv
aluExec.sv
aluSliceTop.sv
aluSlice_chk.sv
tbTop.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the ALU slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tbTop -f src.f -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
